/* common/calc_cfg.svh */
`ifndef CALC_CFG_SVH
`define CALC_CFG_SVH

// Operand and display width
`define CALC_WIDTH 16

`define CALC_DIGIT_WIDTH 4              // Bits added per adder cycle

`define CALC_MULT_STEPS `CALC_WIDTH     // One multiplier bit per step

`endif

/* common/calc_pkg.sv */
`include "calc_cfg.svh"

package calc_pkg;

    // One-hot operator codes as seen on the keypad operator lines
    typedef enum logic [2:0] {
        OP_ADD = 3'b001,                    // Addition
        OP_SUB = 3'b010,                    // Subtraction, wraps
        OP_MUL = 3'b100                     // Multiplication, low half kept
    } calc_op_t;

    // Both operands of one calculation, sent to an engine on start
    typedef struct packed {
        logic [`CALC_WIDTH-1:0] lhs;        // First operand typed
        logic [`CALC_WIDTH-1:0] rhs;        // Second operand typed
    } operand_pair_t;

    // Finished calculation handed to the display
    typedef struct packed {
        logic [`CALC_WIDTH-1:0] value;      // Modulo 2^16 result
        calc_op_t               op;         // Operator that produced it
    } calc_result_t;

endpackage

/* gencon/addition.sv */
`timescale 1ns/1ns
`include "calc_cfg.svh"

module addition import calc_pkg::*; (
    input  logic                   clk,
    input  logic                   nRST,

    input  operand_pair_t          operands,   // Sampled on start only
    input  logic                   sub,        // Difference lhs - rhs
    input  logic                   start,

    output logic [`CALC_WIDTH-1:0] out,
    output logic                   finish
);
    localparam int W      = `CALC_WIDTH;
    localparam int DW     = `CALC_DIGIT_WIDTH;
    localparam int SLICES = W / DW;
    localparam int CNT_W  = $clog2(SLICES + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(SLICES - 1);

    logic [W-1:0]     a_q, b_q;     // Remaining slices, low slice next
    logic             carry_q;
    logic             busy;
    logic [CNT_W-1:0] slice_cnt;
    logic [W-1:0]     a_in, b_in;
    logic             c_in;
    logic [DW:0]      slice_sum;

    // The first slice is added in the start cycle itself
    always_comb begin
        if (start) begin
            a_in = operands.lhs;
            b_in = sub ? ~operands.rhs : operands.rhs;  // Two's complement
            c_in = sub;
        end else begin
            a_in = a_q;
            b_in = b_q;
            c_in = carry_q;
        end
        slice_sum = {1'b0, a_in[DW-1:0]} + {1'b0, b_in[DW-1:0]} + {{DW{1'b0}}, c_in};
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy      <= 1'b0;
            slice_cnt <= '0;
            finish    <= 1'b0;
        end else if (start) begin
            busy      <= 1'b1;
            slice_cnt <= CNT_W'(1);
            finish    <= 1'b0;
        end else if (busy) begin
            slice_cnt <= slice_cnt + 1'b1;
            busy      <= (slice_cnt != LAST);
            finish    <= (slice_cnt == LAST);
        end else begin
            finish    <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            a_q     <= a_in >> DW;
            b_q     <= b_in >> DW;
            carry_q <= slice_sum[DW];
            out     <= {slice_sum[DW-1:0], out[W-1:DW]};  // Fill from the top
        end
    end

endmodule

/* gencon/gencon.sv */
`timescale 1ns/1ns
`include "calc_cfg.svh"

module gencon import calc_pkg::*; (
    input  logic                   clk,
    input  logic                   nRST,

    input  logic [`CALC_WIDTH-1:0] entry_value,    // Operand being typed
    input  logic                   op_strobe,
    input  calc_op_t               op_code,
    input  logic                   equal_strobe,

    output logic                   entry_clear,    // Keypad accumulator to zero
    output calc_result_t           result,
    output logic                   result_strobe
);
    typedef enum logic [2:0] {
        GET_FIRST_NUM    = 3'b000,
        GET_SECOND_NUM   = 3'b001,
        SEND_TO_ALU      = 3'b010,
        WAIT_ALU         = 3'b011,
        SHOW_RESULT_ALU  = 3'b100,
        SHOW_RESULT_MULT = 3'b101
    } state_t;

    state_t current_state, next_state;

    operand_pair_t          operands;    // Shared by both engines
    calc_op_t               op_q;        // Operator of the pending calculation
    logic                   sub_q;
    logic                   start_add;
    logic                   start_mult;
    logic [`CALC_WIDTH-1:0] add_out;
    logic [`CALC_WIDTH-1:0] mult_out;
    logic                   add_finish;
    logic                   mult_finish;

    addition add_calc (
        .clk      (clk),
        .nRST     (nRST),
        .operands (operands),
        .sub      (sub_q),
        .start    (start_add),
        .out      (add_out),
        .finish   (add_finish)
    );

    multiply mult_calc (
        .clk      (clk),
        .nRST     (nRST),
        .operands (operands),
        .start    (start_mult),
        .out      (mult_out),
        .finish   (mult_finish)
    );

    always_comb begin
        next_state = current_state;
        case (current_state)
            GET_FIRST_NUM:  if (op_strobe) next_state = GET_SECOND_NUM;
            GET_SECOND_NUM: if (equal_strobe) next_state = SEND_TO_ALU;
            SEND_TO_ALU:    next_state = WAIT_ALU;
            WAIT_ALU: begin
                if (add_finish) begin
                    next_state = SHOW_RESULT_ALU;
                end else if (mult_finish) begin
                    next_state = SHOW_RESULT_MULT;
                end
            end
            SHOW_RESULT_ALU, SHOW_RESULT_MULT: next_state = GET_FIRST_NUM;
            default:        next_state = GET_FIRST_NUM;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            current_state <= GET_FIRST_NUM;
            op_q          <= OP_ADD;
            sub_q         <= 1'b0;
            start_add     <= 1'b0;
            start_mult    <= 1'b0;
        end else begin
            current_state <= next_state;
            if (current_state == GET_FIRST_NUM && op_strobe) begin
                op_q <= op_code;
            end
            // Dispatch leaves SEND with a one-cycle start
            start_add  <= (current_state == SEND_TO_ALU) && (op_q != OP_MUL);
            start_mult <= (current_state == SEND_TO_ALU) && (op_q == OP_MUL);
            if (current_state == SEND_TO_ALU) begin
                sub_q <= (op_q == OP_SUB);  // Subtract runs on the adder
            end
        end
    end

    always_ff @(posedge clk) begin
        if (current_state == GET_FIRST_NUM && op_strobe) begin
            operands.lhs <= entry_value;
        end
        if (current_state == GET_SECOND_NUM && equal_strobe) begin
            operands.rhs <= entry_value;
        end
    end

    always_comb begin
        // Digits typed outside operand entry are dropped
        entry_clear   = (current_state == GET_FIRST_NUM && op_strobe)
                     || (current_state inside {SEND_TO_ALU, WAIT_ALU,
                                               SHOW_RESULT_ALU, SHOW_RESULT_MULT});
        result_strobe = current_state inside {SHOW_RESULT_ALU, SHOW_RESULT_MULT};
        result.value  = (current_state == SHOW_RESULT_MULT) ? mult_out : add_out;
        result.op     = op_q;
    end

endmodule

/* gencon/multiply.sv */
`timescale 1ns/1ns
`include "calc_cfg.svh"

module multiply import calc_pkg::*; (
    input  logic                   clk,
    input  logic                   nRST,

    input  operand_pair_t          operands,   // Sampled on start only
    input  logic                   start,

    output logic [`CALC_WIDTH-1:0] out,
    output logic                   finish
);
    localparam int W     = `CALC_WIDTH;
    localparam int STEPS = `CALC_MULT_STEPS;
    localparam int CNT_W = $clog2(STEPS + 1);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(STEPS - 1);

    logic [W-1:0]     mcand_q;      // Multiplicand, shifted left each step
    logic [W-1:0]     mplier_q;     // Multiplier, low bit examined
    logic [W-1:0]     prod_q;       // Low half of the partial product
    logic             busy;
    logic [CNT_W-1:0] step_cnt;
    logic [W-1:0]     mcand_in, mplier_in, prod_in;
    logic [W-1:0]     prod_next;

    // Step zero happens in the start cycle
    always_comb begin
        if (start) begin
            mcand_in  = operands.lhs;
            mplier_in = operands.rhs;
            prod_in   = '0;
        end else begin
            mcand_in  = mcand_q;
            mplier_in = mplier_q;
            prod_in   = prod_q;
        end
        prod_next = prod_in + (mplier_in[0] ? mcand_in : '0);  // Carry out dropped
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            finish   <= 1'b0;
        end else if (start) begin
            busy     <= 1'b1;
            step_cnt <= CNT_W'(1);
            finish   <= 1'b0;
        end else if (busy) begin
            step_cnt <= step_cnt + 1'b1;
            busy     <= (step_cnt != LAST);
            finish   <= (step_cnt == LAST);
        end else begin
            finish   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            mcand_q  <= mcand_in << 1;
            mplier_q <= mplier_in >> 1;
            prod_q   <= prod_next;
        end
    end

    assign out = prod_q;  // Final once finish pulses

endmodule

/* project.f */
+incdir+common
common/calc_pkg.sv
verilog/keypad_entry.sv
gencon/addition.sv
gencon/multiply.sv
gencon/gencon.sv
verilog/result_display.sv
verilog/calc_top.sv
tests/calc_properties.sv
tests/calc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the calculator testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module calc_tb -f project.f -o calc_sim

status=0
./obj_dir/calc_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"

/* tests/calc_golden.txt */
# command  operand1_keys  operator_codes  operand2_keys  expected_display  name
# keys a-f are codes 10-15; operator chars are 3-bit codes (1 add, 2 sub, 4 mul, 3 illegal)
calc 123 1 4567 4690 add_multi
calc 65000 1 1000 464 add_wrap
calc 5 2 7 65534 sub_wrap
calc 4567 2 123 4444 sub_plain
calc 300 4 300 24464 mul_wrap
calc 12 4 34 408 mul_small
calc 1a2b3 31 45f67 4690 ignore_codes
idle - - - 4690 idle_hold
calc 0 1 0 0 add_zero
calc 70000 1 1 4465 entry_wrap
calc 65535 4 65535 1 mul_max
reset - - - 0 reset_mid
calc 250 4 4 1000 after_reset

/* tests/calc_properties.sv */
`timescale 1ns/1ns
`include "calc_cfg.svh"

module calc_properties (
    input logic                   clk,
    input logic                   nRST,
    input logic                   complete,
    input logic [`CALC_WIDTH-1:0] display_output,
    input logic                   start_add,
    input logic                   start_mult,
    input logic                   add_busy,
    input logic                   mult_busy
);
    complete_single: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)                     // One pulse per result
        else $error("complete high for two cycles in a row");

    // A new dispatch only once both engines are idle
    engines_exclusive: assert property (@(posedge clk) disable iff (!nRST)
        (start_add || start_mult) |-> !(add_busy || mult_busy))
        else $error("an engine started while another calculation was running");

    reset_clear: assert property (@(posedge clk)
        !nRST |-> (!complete && display_output == '0))
        else $error("complete or display not zero during reset");

    display_on_complete: assert property (@(posedge clk) disable iff (!nRST)
        $changed(display_output) |-> $rose(complete))
        else $error("display changed without a complete pulse");

endmodule

bind calc_top calc_properties u_props (
    .clk            (clk),
    .nRST           (nRST),
    .complete       (complete),
    .display_output (display_output),
    .start_add      (u_gencon.start_add),
    .start_mult     (u_gencon.start_mult),
    .add_busy       (u_gencon.add_calc.busy),
    .mult_busy      (u_gencon.mult_calc.busy)
);

/* tests/calc_tb.sv */
`timescale 1ns/1ns
`include "calc_cfg.svh"

module calc_tb;
    localparam int TIMEOUT = 100;       // Cycles allowed from equal to complete

    logic                   clk;
    logic                   nRST;
    logic [3:0]             keypad_input;
    logic                   read_input;
    logic [2:0]             operator_input;
    logic                   equal_input;
    logic                   complete;
    logic [`CALC_WIDTH-1:0] display_output;
    int                     completes = 0;      // complete pulses seen so far

    calc_top u_dut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Counted on the rising edge that ends the pulse
    always @(posedge clk) begin
        if (complete) begin
            completes <= completes + 1;
        end
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        stop_with_error($sformatf("[FAIL] %s: expected %0d, actual %0d", name, expected, actual));
    endtask

    // Digits 0-9 as typed, letters a-f give the illegal codes 10-15
    task automatic type_keys(input string keys);
        logic [3:0] code;
        int         i;
        for (i = 0; i < keys.len(); i++) begin
            if (keys[i] >= "a") begin
                code = 4'(keys[i] - "a" + 10);
            end else begin
                code = 4'(keys[i] - "0");
            end
            @(posedge clk);
            keypad_input <= code;
            read_input   <= 1'b1;
        end
        @(posedge clk);
        read_input <= 1'b0;
    endtask

    // Each character is one value of the operator lines, released to 000 after it
    task automatic press_operator(input string ops);
        int i;
        for (i = 0; i < ops.len(); i++) begin
            @(posedge clk);
            operator_input <= 3'(ops[i] - "0");
            @(posedge clk);
            operator_input <= 3'b000;
        end
    endtask

    task automatic press_equal();
        @(posedge clk);
        equal_input <= 1'b1;
        @(posedge clk);
        equal_input <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        nRST <= 1'b0;
        repeat (4) @(posedge clk);
        nRST <= 1'b1;
    endtask

    task automatic wait_for_complete(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!complete && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        assert (complete) else
            stop_with_error($sformatf("%s: no complete pulse within %0d cycles", name, TIMEOUT));
    endtask

    // Display must stay put with no further complete pulse
    task automatic check_held(input string name, input int expected, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!complete) else
                stop_with_error($sformatf("%s: extra complete pulse", name));
            assert (int'(display_output) == expected) else
                report_mismatch(name, expected, int'(display_output));
        end
    endtask

    // Keypad activity while idle that must not reach the display
    task automatic idle_activity();
        press_equal();
        press_operator("3");
        type_keys("abcdef");
    endtask

    initial begin
        int    fd;
        int    fields;
        int    exp_int;
        int    pulses_before;
        int    pulses_expected;
        string line;
        string cmd;
        string keys_a;
        string ops;
        string keys_b;
        string name;
        keypad_input   = 4'd0;
        read_input     = 1'b0;
        operator_input = 3'b000;
        equal_input    = 1'b0;
        nRST           = 1'b0;
        repeat (4) @(posedge clk);
        nRST <= 1'b1;

        fd = $fopen("tests/calc_golden.txt", "r");
        assert (fd != 0) else stop_with_error("cannot open tests/calc_golden.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin      // Skip comments and blanks
                fields = $sscanf(line, "%s %s %s %s %d %s",
                                 cmd, keys_a, ops, keys_b, exp_int, name);
                assert (fields == 6) else stop_with_error({"malformed golden line: ", line});
                pulses_before   = completes;
                pulses_expected = 0;                         // Only a calculation completes
                case (cmd)
                    "calc": begin
                        pulses_expected = 1;
                        type_keys(keys_a);
                        press_operator(ops);
                        type_keys(keys_b);
                        press_equal();
                        wait_for_complete(name);
                        assert (int'(display_output) == exp_int) else
                            report_mismatch(name, exp_int, int'(display_output));
                    end
                    "idle":  idle_activity();
                    "reset": apply_reset();
                    default: stop_with_error({"unknown command in golden file: ", cmd});
                endcase
                check_held(name, exp_int, 5);
                assert (completes == pulses_before + pulses_expected) else
                    report_mismatch({name, " complete pulses"}, pulses_expected,
                                    completes - pulses_before);
            end
        end
        $fclose(fd);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* verilog/calc_top.sv */
`timescale 1ns/1ns
`include "calc_cfg.svh"

module calc_top import calc_pkg::*; (
    input  logic                   clk,
    input  logic                   nRST,

    input  logic [3:0]             keypad_input,
    input  logic                   read_input,
    input  logic [2:0]             operator_input,
    input  logic                   equal_input,

    output logic                   complete,
    output logic [`CALC_WIDTH-1:0] display_output
);
    logic [`CALC_WIDTH-1:0] entry_value;
    logic                   op_strobe;
    calc_op_t               op_code;
    logic                   equal_strobe;
    logic                   entry_clear;
    calc_result_t           result;
    logic                   result_strobe;

    keypad_entry u_entry (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .entry_clear    (entry_clear),
        .entry_value    (entry_value),
        .op_strobe      (op_strobe),
        .op_code        (op_code),
        .equal_strobe   (equal_strobe)
    );

    gencon u_gencon (
        .clk           (clk),
        .nRST          (nRST),
        .entry_value   (entry_value),
        .op_strobe     (op_strobe),
        .op_code       (op_code),
        .equal_strobe  (equal_strobe),
        .entry_clear   (entry_clear),
        .result        (result),
        .result_strobe (result_strobe)
    );

    result_display u_display (
        .clk            (clk),
        .nRST           (nRST),
        .result         (result),
        .result_strobe  (result_strobe),
        .display_output (display_output),
        .complete       (complete)
    );

endmodule

/* verilog/keypad_entry.sv */
`timescale 1ns/1ns
`include "calc_cfg.svh"

module keypad_entry import calc_pkg::*; (
    input  logic                   clk,
    input  logic                   nRST,

    input  logic [3:0]             keypad_input,   // One decimal digit per read
    input  logic                   read_input,     // Take keypad_input this cycle
    input  logic [2:0]             operator_input, // Level, one-hot when legal
    input  logic                   equal_input,
    input  logic                   entry_clear,    // Hold operand at zero

    output logic [`CALC_WIDTH-1:0] entry_value,
    output logic                   op_strobe,
    output calc_op_t               op_code,
    output logic                   equal_strobe
);
    logic [2:0] op_prev;       // Last cycle's operator lines
    logic       equal_prev;
    logic       op_legal;
    logic       digit_ok;

    always_comb begin
        op_legal = operator_input inside {OP_ADD, OP_SUB, OP_MUL};
        digit_ok = read_input && (keypad_input <= 4'd9);  // Codes 10-15 dropped
    end

    // Operand accumulator, value * 10 + digit
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            entry_value <= '0;
        end else if (entry_clear) begin
            entry_value <= '0;
        end else if (digit_ok) begin
            entry_value <= (entry_value << 3) + (entry_value << 1)
                         + {{(`CALC_WIDTH-4){1'b0}}, keypad_input};
        end
    end

    // A held key gives a single strobe
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            op_prev      <= 3'b000;
            equal_prev   <= 1'b0;
            op_strobe    <= 1'b0;
            equal_strobe <= 1'b0;
            op_code      <= OP_ADD;
        end else begin
            op_prev      <= operator_input;
            equal_prev   <= equal_input;
            op_strobe    <= op_legal && (operator_input != op_prev);
            equal_strobe <= equal_input && !equal_prev;
            if (op_legal) begin
                op_code <= calc_op_t'(operator_input);
            end
        end
    end

endmodule

/* verilog/result_display.sv */
`timescale 1ns/1ns
`include "calc_cfg.svh"

module result_display import calc_pkg::*; (
    input  logic                   clk,
    input  logic                   nRST,

    input  calc_result_t           result,
    input  logic                   result_strobe,   // One pulse per calculation

    output logic [`CALC_WIDTH-1:0] display_output,
    output logic                   complete
);
    logic show;

    // Only results of a known operator reach the display
    always_comb begin
        show = result_strobe && (result.op inside {OP_ADD, OP_SUB, OP_MUL});
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            display_output <= '0;
            complete       <= 1'b0;
        end else begin
            complete <= show;           // Single-cycle pulse
            if (show) begin
                display_output <= result.value;  // Held until the next result
            end
        end
    end

endmodule
